/* include/uart_cfg.svh */
// Build-time settings for the serial echo path
// Bit period, character width and FIFO depth
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Clocks per serial bit
// 125 MHz / 1085 is close to 115200 baud
`define UART_CLKS_PER_BIT 1085

// Data bits per character, fixed 8N1 format
`define UART_DATA_BITS 8

// Echo buffer entries, must be a power of two
`define UART_FIFO_DEPTH 256

`endif

/* source/uart_pkg.sv */
// Shared types for the serial echo path
// Character, stage-to-stage beat and LED status word
`include "uart_cfg.svh"

package uart_pkg;

    // One serial character
    typedef logic [`UART_DATA_BITS-1:0] uart_data_t;

    // Byte moving between stages with its qualifier
    typedef struct packed {
        logic       valid;
        uart_data_t data;
    } uart_beat_t;

    // Status lights, frame_err is the top bit
    typedef struct packed {
        logic frame_err;
        logic fifo_nonempty;
        logic tx_busy;
    } led_status_t;

endpackage

/* source/uart_rx.sv */
// UART receiver for 8N1 characters
// Samples each bit at its middle and flags a low stop bit
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_rx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_rxd,
    output uart_pkg::uart_beat_t o_beat,
    output logic                 o_frame_err
);
    import uart_pkg::*;

    localparam int CNT_W     = $clog2(CLKS_PER_BIT);
    localparam int DATA_BITS = $bits(uart_data_t);
    localparam int BIT_W     = $clog2(DATA_BITS);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_BITS - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rxd_meta;
    logic             rxd_sync;
    logic             rxd_last;
    logic [CNT_W-1:0] clk_cnt;
    logic [BIT_W-1:0] bit_cnt;
    uart_data_t       shift_q;
    logic             valid_q;
    logic             frame_err_q;
    logic             bit_tick;

    assign bit_tick = (clk_cnt == '0);

    // Line idles high, so the synchronizer starts high too
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_last <= 1'b1;
        end else begin
            rxd_meta <= i_rxd;
            rxd_sync <= rxd_meta;
            rxd_last <= rxd_sync;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= RX_IDLE;
            clk_cnt     <= '0;
            bit_cnt     <= '0;
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // Falling edge marks a possible start bit
                    if (rxd_last && !rxd_sync) begin
                        state   <= RX_START;
                        clk_cnt <= HALF_BIT;
                    end
                end
                RX_START: begin
                    if (!bit_tick) begin
                        clk_cnt <= clk_cnt - 1'b1;
                    end else if (rxd_sync) begin
                        // High at mid start bit, just a glitch
                        state <= RX_IDLE;
                    end else begin
                        state   <= RX_DATA;
                        clk_cnt <= FULL_BIT;
                        bit_cnt <= '0;
                    end
                end
                RX_DATA: begin
                    if (!bit_tick) begin
                        clk_cnt <= clk_cnt - 1'b1;
                    end else begin
                        clk_cnt <= FULL_BIT;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (!bit_tick) begin
                        clk_cnt <= clk_cnt - 1'b1;
                    end else begin
                        state       <= RX_IDLE;
                        valid_q     <= rxd_sync;
                        frame_err_q <= !rxd_sync;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && bit_tick) begin
            shift_q <= {rxd_sync, shift_q[DATA_BITS-1:1]};
        end
    end

    assign o_beat.valid = valid_q;
    assign o_beat.data  = shift_q;
    assign o_frame_err  = frame_err_q;

endmodule

/* source/uart_tx.sv */
// UART transmitter for 8N1 characters
// Pops a byte when idle and shifts the frame out LSB first
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  uart_pkg::uart_beat_t i_head,
    output logic                 o_pop,
    output logic                 o_txd,
    output logic                 o_busy
);
    import uart_pkg::*;

    localparam int CNT_W      = $clog2(CLKS_PER_BIT);
    localparam int FRAME_BITS = $bits(uart_data_t) + 2;
    localparam int BIT_W      = $clog2(FRAME_BITS);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(FRAME_BITS - 1);

    logic [FRAME_BITS-1:0] frame_q;
    logic [CNT_W-1:0]      clk_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic                  busy_q;
    logic                  pop;

    // Accept only from idle, busy is the sole back-pressure
    assign pop = i_head.valid && !busy_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy_q  <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            frame_q <= '1;
        end else if (pop) begin
            busy_q  <= 1'b1;
            clk_cnt <= FULL_BIT;
            bit_cnt <= '0;
            // Stop, data, start from top to bottom
            frame_q <= {1'b1, i_head.data, 1'b0};
        end else if (busy_q) begin
            if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= FULL_BIT;
                bit_cnt <= bit_cnt + 1'b1;
                // Ones fill in behind, line ends high
                frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
                if (bit_cnt == LAST_BIT) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    assign o_pop  = pop;
    assign o_txd  = frame_q[0];
    // Busy already in the pop cycle
    assign o_busy = busy_q || pop;

endmodule

/* source/byte_fifo.sv */
// First-word-fall-through byte FIFO
// Circular buffer with wrap-bit pointers, drops writes when full
`timescale 1ns/100ps
`include "uart_cfg.svh"

module byte_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  uart_pkg::uart_beat_t i_wr,
    input  logic                 i_pop,
    output uart_pkg::uart_beat_t o_rd
);
    import uart_pkg::*;

    localparam int AW = $clog2(DEPTH);

    uart_data_t  mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        empty;
    logic        full;
    logic        do_write;
    logic        do_read;

    // Same index with opposite wrap bits means full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_write = i_wr.valid && !full;
    assign do_read  = i_pop && !empty;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= i_wr.data;
        end
    end

    // Head is read combinationally so it shows one cycle after the write
    assign o_rd.valid = !empty;
    assign o_rd.data  = mem[rd_ptr[AW-1:0]];

endmodule

/* source/uart_echo_core.sv */
// Serial echo core
// Receiver, byte FIFO and transmitter with three status LEDs
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_echo_core #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT,
    parameter int DEPTH        = `UART_FIFO_DEPTH
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_uart_rxd,
    output logic                  o_uart_txd,
    output uart_pkg::led_status_t o_led
);
    import uart_pkg::*;

    uart_beat_t rx_beat;
    uart_beat_t fifo_head;
    logic       rx_frame_err;
    logic       tx_pop;
    logic       tx_busy;
    logic       frame_err_seen;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_rx (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rxd        (i_uart_rxd),
        .o_beat       (rx_beat),
        .o_frame_err  (rx_frame_err)
    );

    byte_fifo #(
        .DEPTH        (DEPTH)
    ) u_byte_fifo (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_wr         (rx_beat),
        .i_pop        (tx_pop),
        .o_rd         (fifo_head)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_head       (fifo_head),
        .o_pop        (tx_pop),
        .o_txd        (o_uart_txd),
        .o_busy       (tx_busy)
    );

    // Framing error stays lit until reset
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            frame_err_seen <= 1'b0;
        end else if (rx_frame_err) begin
            frame_err_seen <= 1'b1;
        end
    end

    assign o_led.frame_err     = frame_err_seen;
    assign o_led.fifo_nonempty = fifo_head.valid;
    assign o_led.tx_busy       = tx_busy;

endmodule

/* testbench/tb_uart_echo.sv */
// Testbench for the serial echo core
// Drives 8N1 characters into the receiver and checks the echoed stream
`timescale 1ns/100ps

module tb_uart_echo;
    import uart_pkg::*;

    localparam int BIT_CLKS       = 16;
    localparam int FIFO_DEPTH     = 8;
    localparam int FRAME_BITS     = 10;
    localparam int RESET_CYCLES   = 4;
    localparam int BURST_LEN      = 20;
    localparam int TIMEOUT_CYCLES = 40 * FRAME_BITS * BIT_CLKS * 2;

    logic        clk;
    logic        reset;
    logic        uart_rxd;
    logic        uart_txd;
    led_status_t led;

    uart_data_t  exp_q[$];
    integer      seed = 32'h6e657313;
    int          cycle_cnt = 0;
    logic        reset_done = 1'b0;
    logic        burst_active = 1'b0;
    logic        seen_nonempty = 1'b0;
    logic        frame_err_expected = 1'b0;

    uart_echo_core #(
        .CLKS_PER_BIT (BIT_CLKS),
        .DEPTH        (FIFO_DEPTH)
    ) u_uart_echo_core (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_uart_rxd   (uart_rxd),
        .o_uart_txd   (uart_txd),
        .o_led        (led)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        abort_run();
    endtask

    // Start, eight data bits LSB first, then the given stop level
    task automatic send_char(input uart_data_t data, input logic stop_level);
        logic [FRAME_BITS-1:0] frame;
        frame = {stop_level, data, 1'b0};
        if (stop_level) begin
            exp_q.push_back(data);
        end
        for (int i = 0; i < FRAME_BITS; i++) begin
            @(negedge clk);
            uart_rxd = frame[i];
            repeat (BIT_CLKS - 1) @(negedge clk);
        end
    endtask

    // Monitor empties the queue at each echoed stop bit
    // Each pending byte gets at most one frame time, plus one frame of slack
    task automatic wait_for_echoes();
        int limit;
        int waited;
        limit  = (exp_q.size() + 1) * FRAME_BITS * BIT_CLKS;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        // Let the last stop bit run out
        repeat (2 * BIT_CLKS) @(negedge clk);
    endtask

    task automatic check_idle(input string where);
        assert (uart_txd == 1'b1)
            else report_mismatch({"txd not high when idle ", where});
        assert (led.fifo_nonempty == 1'b0)
            else report_mismatch({"fifo_nonempty still high ", where});
        assert (led.tx_busy == 1'b0)
            else report_mismatch({"tx_busy still high ", where});
        assert (led.frame_err == frame_err_expected)
            else report_mismatch({"frame_err LED wrong ", where});
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles",
                     TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // Burst occupancy and sticky frame error
    always @(negedge clk) begin
        if (reset_done) begin
            if (burst_active && led.fifo_nonempty) begin
                seen_nonempty = 1'b1;
            end
            if (frame_err_expected) begin
                assert (led.frame_err)
                    else report_mismatch("frame_err LED dropped after being set");
            end
        end
    end

    // Rebuilds each echoed character from the mid-bit samples
    initial begin : echo_monitor
        uart_data_t got;
        uart_data_t want;
        wait (reset_done);
        forever begin
            @(negedge uart_txd);
            repeat (BIT_CLKS / 2) @(negedge clk);
            assert (uart_txd == 1'b0)
                else report_mismatch("echo start bit not low at its middle");
            assert (led.tx_busy)
                else report_mismatch("tx_busy low during start bit");
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge clk);
                got[i] = uart_txd;
                assert (led.tx_busy)
                    else report_mismatch("tx_busy low during a data bit");
            end
            repeat (BIT_CLKS) @(negedge clk);
            assert (uart_txd == 1'b1)
                else report_mismatch("echo stop bit not high");
            assert (led.tx_busy)
                else report_mismatch("tx_busy low during stop bit");
            assert (exp_q.size() != 0)
                else report_mismatch($sformatf("unexpected echo of 0x%02h", got));
            want = exp_q.pop_front();
            assert (got == want)
                else report_mismatch($sformatf("echo 0x%02h, expected 0x%02h", got, want));
        end
    end

    initial begin : stimulus
        uart_data_t value;
        reset = 1'b1;
        uart_rxd = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        reset_done = 1'b1;

        // State right after reset
        @(negedge clk);
        assert (uart_txd == 1'b1)
            else report_mismatch("txd not high after reset");
        assert (led == '0)
            else report_mismatch($sformatf("LEDs 0x%0h after reset", led));

        // Single character
        send_char(8'hA5, 1'b1);
        wait_for_echoes();
        check_idle("after single byte");

        // Back-to-back burst
        burst_active = 1'b1;
        for (int n = 0; n < BURST_LEN; n++) begin
            value = uart_data_t'($random(seed));
            send_char(value, 1'b1);
        end
        burst_active = 1'b0;
        wait_for_echoes();
        assert (seen_nonempty)
            else report_mismatch("fifo_nonempty never high during burst");
        check_idle("after burst");

        // Low stop bit, then return the line to idle
        value = uart_data_t'($random(seed));
        send_char(value, 1'b0);
        @(negedge clk);
        uart_rxd = 1'b1;
        repeat (2 * BIT_CLKS) @(negedge clk);
        assert (led.frame_err)
            else report_mismatch("frame_err LED not set by low stop bit");
        frame_err_expected = 1'b1;
        repeat (FRAME_BITS * BIT_CLKS) @(negedge clk);
        check_idle("after framing error");

        // Echo still works after the error
        for (int n = 0; n < 3; n++) begin
            value = uart_data_t'($random(seed));
            send_char(value, 1'b1);
        end
        wait_for_echoes();
        check_idle("at end of run");

        if (exp_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_mismatch($sformatf("%0d echoes missing", exp_q.size()));
        end
    end

endmodule

/* src.f */
+incdir+include
source/uart_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/byte_fifo.sv
source/uart_echo_core.sv
testbench/tb_uart_echo.sv

/* Makefile */
# Verilator flow for the serial echo core
# Every variable below can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_uart_echo
RTL_TOP   ?= uart_echo_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 4

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# A $fatal in the testbench gives a nonzero exit status, which fails this target
sim: build
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
